//--- rtl/imgproc_cfg.svh
// image processor configuration
`ifndef IMGPROC_CFG_SVH
`define IMGPROC_CFG_SVH

// frame geometry
`define IMG_W 640
`define IMG_H 480
`define HORIZON_Y 280
`define RUN_LEN 6

// detection windows, hue is in half degrees
`define RED_HUE_LO 172
`define RED_HUE_HI 6
`define RED_SAT_MIN 102
`define RED_VAL_MIN 105
`define YEL_HUE_LO 16
`define YEL_HUE_HI 30
`define YEL_SAT_MIN 133
`define YEL_VAL_MIN 124

// overlay colours
`define RED_FILL 24'hff1000
`define YEL_FILL 24'hffff00
`define RED_BOX 24'hff0000
`define YEL_BOX 24'hffff00

// message writer, "RBB" in ascii
`define MSG_ID 32'h00524242
`define MSG_INTERVAL 6
`define MSG_FIFO_DEPTH 16
`define MSG_FIFO_AW 4

// register map
`define ADDR_STATUS 3'd0
`define ADDR_MSG 3'd1
`define ADDR_ID 3'd2
`define ID_WORD 32'h1234eee2
`define FLUSH_BIT 4

`endif

//--- rtl/imgproc_pkg.sv
// image processor types
package imgproc_pkg;

	// 24-bit pixel, red in the high byte
	typedef logic [23:0] rgb_t;
	// one colour channel or hsv component
	typedef logic [7:0] chan_t;
	// x or y position in a frame
	typedef logic [10:0] coord_t;
	// message and register word
	typedef logic [31:0] word_t;
	// message fifo fill level
	typedef logic [6:0] fill_t;

	typedef enum logic [1:0] {
		CLASS_NONE,
		CLASS_RED,
		CLASS_YELLOW
	} pix_class_t;

	typedef enum logic [1:0] {
		MSG_IDLE,
		MSG_ID,
		MSG_RED,
		MSG_YELLOW
	} msg_state_t;

endpackage

//--- rtl/stream_reg.sv
// valid/ready pipeline stage
module stream_reg (
	input  logic              clk,
	input  logic              reset_n,
	input  imgproc_pkg::rgb_t data_in,
	input  logic              sop_in,
	input  logic              eop_in,
	input  logic              valid_in,
	output logic              ready_out,
	output imgproc_pkg::rgb_t data_out,
	output logic              sop_out,
	output logic              eop_out,
	output logic              valid_out,
	input  logic              ready_in
);

	// take a new word when empty or when the held word leaves this cycle
	assign ready_out = !valid_out || ready_in;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			valid_out <= 1'b0;
		end else if (ready_out) begin
			valid_out <= valid_in;
		end
	end

	// payload follows the same load condition
	always_ff @(posedge clk) begin
		if (ready_out) begin
			data_out <= data_in;
			sop_out <= sop_in;
			eop_out <= eop_in;
		end
	end

endmodule

//--- rtl/pixel_classify.sv
// rgb to hsv colour classifier
`include "imgproc_cfg.svh"

module pixel_classify (
	input  logic                    clk,
	input  logic                    reset_n,
	input  imgproc_pkg::rgb_t       pixel,
	input  logic                    sop,
	input  logic                    pix_accept,
	output imgproc_pkg::pix_class_t pix_class
);

	localparam int cnt_w = $clog2(`RUN_LEN + 1);

	imgproc_pkg::chan_t r, g, b;
	imgproc_pkg::chan_t val, vmin, sat, hue;
	int diff, num;
	logic red_hit, yel_hit;
	logic [cnt_w-1:0] red_cnt, yel_cnt;

	assign r = pixel[23:16];
	assign g = pixel[15:8];
	assign b = pixel[7:0];

	//////////////////////////////
	// hsv conversion
	//////////////////////////////
	assign val = (r > g) ? ((r > b) ? r : b) : ((g > b) ? g : b);
	assign vmin = (r < g) ? ((r < b) ? r : b) : ((g < b) ? g : b);

	always_comb begin
		diff = int'(val) - int'(vmin);
		num = 0;
		sat = '0;
		hue = '0;
		if (val != 0) begin
			sat = imgproc_pkg::chan_t'((diff * 255) / int'(val));
		end
		// 0..360 degree hue halved to fit a byte
		if (diff != 0) begin
			if (val != r && val != g) begin
				num = 240 * diff + 60 * (int'(r) - int'(g));
			end else if (val != r) begin
				num = 120 * diff + 60 * (int'(b) - int'(r));
			end else if (b <= g) begin
				num = 60 * (int'(g) - int'(b));
			end else begin
				num = 360 * diff + 60 * (int'(g) - int'(b));
			end
			hue = imgproc_pkg::chan_t'((num / diff) >> 1);
		end
	end

	//////////////////////////////
	// colour windows
	//////////////////////////////
	// red wraps around hue zero and wins over yellow
	assign red_hit = (hue >= `RED_HUE_LO || hue <= `RED_HUE_HI)
		&& sat > `RED_SAT_MIN && val > `RED_VAL_MIN;
	assign yel_hit = !red_hit && hue >= `YEL_HUE_LO && hue <= `YEL_HUE_HI
		&& sat > `YEL_SAT_MIN && val > `YEL_VAL_MIN;

	// run counters hold the length of the preceding matching run
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			red_cnt <= '0;
			yel_cnt <= '0;
		end else if (pix_accept) begin
			if (sop || !red_hit) begin
				red_cnt <= '0;
			end else if (red_cnt != cnt_w'(`RUN_LEN)) begin
				red_cnt <= red_cnt + 1'b1;
			end
			if (sop || !yel_hit) begin
				yel_cnt <= '0;
			end else if (yel_cnt != cnt_w'(`RUN_LEN)) begin
				yel_cnt <= yel_cnt + 1'b1;
			end
		end
	end

	always_comb begin
		if (red_hit && red_cnt == cnt_w'(`RUN_LEN)) begin
			pix_class = imgproc_pkg::CLASS_RED;
		end else if (yel_hit && yel_cnt == cnt_w'(`RUN_LEN)) begin
			pix_class = imgproc_pkg::CLASS_YELLOW;
		end else begin
			pix_class = imgproc_pkg::CLASS_NONE;
		end
	end

endmodule

//--- rtl/frame_tracker.sv
// frame coordinates, bounding boxes and overlay
`include "imgproc_cfg.svh"

module frame_tracker #(
	parameter int img_w = `IMG_W,
	parameter int img_h = `IMG_H,
	parameter int horizon_y = `HORIZON_Y
) (
	input  logic                    clk,
	input  logic                    reset_n,
	input  logic                    mode,
	input  imgproc_pkg::rgb_t       pixel,
	input  logic                    sop,
	input  logic                    eop,
	input  logic                    pix_accept,
	input  imgproc_pkg::pix_class_t pix_class,
	output imgproc_pkg::rgb_t       out_pixel,
	output logic                    msg_start,
	output imgproc_pkg::coord_t     red_left,
	output imgproc_pkg::coord_t     red_right,
	output imgproc_pkg::coord_t     yel_left,
	output imgproc_pkg::coord_t     yel_right
);

	localparam imgproc_pkg::coord_t x_last = imgproc_pkg::coord_t'(img_w - 1);
	localparam int fc_w = $clog2(`MSG_INTERVAL);

	imgproc_pkg::coord_t x, y;
	imgproc_pkg::coord_t red_min, red_max, yel_min, yel_max;
	imgproc_pkg::coord_t red_min_nx, red_max_nx, yel_min_nx, yel_max_nx;
	imgproc_pkg::chan_t grey;
	imgproc_pkg::rgb_t base_pixel, boxed_pixel;
	logic packet_video, in_roi, take_pix, frame_end;
	logic [fc_w-1:0] frame_cnt;

	// first pixel after the packet descriptor is x = 0
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			x <= '0;
			y <= '0;
			packet_video <= 1'b0;
		end else if (pix_accept && sop) begin
			x <= '0;
			y <= '0;
			packet_video <= (pixel[3:0] == 4'h0);
		end else if (pix_accept) begin
			if (x == x_last) begin
				x <= '0;
				y <= y + 1'b1;
			end else begin
				x <= x + 1'b1;
			end
		end
	end

	//////////////////////////////
	// box accumulation
	//////////////////////////////
	assign in_roi = y > imgproc_pkg::coord_t'(horizon_y) && y < imgproc_pkg::coord_t'(img_h);
	assign take_pix = pix_accept && !sop && in_roi;
	assign frame_end = pix_accept && eop && !sop && packet_video;

	// the eop pixel itself still counts towards the box
	always_comb begin
		red_min_nx = red_min;
		red_max_nx = red_max;
		yel_min_nx = yel_min;
		yel_max_nx = yel_max;
		if (take_pix && pix_class == imgproc_pkg::CLASS_RED) begin
			red_min_nx = (x < red_min) ? x : red_min;
			red_max_nx = (x > red_max) ? x : red_max;
		end
		if (take_pix && pix_class == imgproc_pkg::CLASS_YELLOW) begin
			yel_min_nx = (x < yel_min) ? x : yel_min;
			yel_max_nx = (x > yel_max) ? x : yel_max;
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n || (pix_accept && sop)) begin
			red_min <= x_last;
			red_max <= '0;
			yel_min <= x_last;
			yel_max <= '0;
		end else begin
			red_min <= red_min_nx;
			red_max <= red_max_nx;
			yel_min <= yel_min_nx;
			yel_max <= yel_max_nx;
		end
	end

	// latch edges for the next frame and pace the message writer
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			red_left <= x_last;
			red_right <= '0;
			yel_left <= x_last;
			yel_right <= '0;
			frame_cnt <= '0;
			msg_start <= 1'b0;
		end else begin
			msg_start <= 1'b0;
			if (frame_end) begin
				red_left <= red_min_nx;
				red_right <= red_max_nx;
				yel_left <= yel_min_nx;
				yel_right <= yel_max_nx;
				if (frame_cnt == '0) begin
					msg_start <= 1'b1;
					frame_cnt <= fc_w'(`MSG_INTERVAL - 1);
				end else begin
					frame_cnt <= frame_cnt - 1'b1;
				end
			end
		end
	end

	//////////////////////////////
	// output pixel
	//////////////////////////////
	// grey = g/2 + r/4 + b/4
	assign grey = {1'b0, pixel[15:9]} + {2'b0, pixel[23:18]} + {2'b0, pixel[7:2]};

	always_comb begin
		case (pix_class)
			imgproc_pkg::CLASS_RED: base_pixel = `RED_FILL;
			imgproc_pkg::CLASS_YELLOW: base_pixel = `YEL_FILL;
			default: base_pixel = {grey, grey, grey};
		endcase
		boxed_pixel = base_pixel;
		// an edge at its reset value means no box
		if ((x == red_left && red_left != x_last) || (x == red_right && red_right != '0)) begin
			boxed_pixel = `RED_BOX;
		end
		if ((x == yel_left && yel_left != x_last) || (x == yel_right && yel_right != '0)) begin
			boxed_pixel = `YEL_BOX;
		end
	end

	// descriptor words and non-video packets pass untouched
	assign out_pixel = (mode && !sop && packet_video) ? boxed_pixel : pixel;

endmodule

//--- rtl/msg_fifo.sv
// message writer and message fifo
`include "imgproc_cfg.svh"

module msg_fifo (
	input  logic                clk,
	input  logic                reset_n,
	input  logic                msg_start,
	input  imgproc_pkg::coord_t red_left,
	input  imgproc_pkg::coord_t red_right,
	input  imgproc_pkg::coord_t yel_left,
	input  imgproc_pkg::coord_t yel_right,
	input  logic                msg_pop,
	input  logic                msg_flush,
	output imgproc_pkg::word_t  msg_q,
	output imgproc_pkg::fill_t  msg_fill,
	output logic                msg_empty
);

	imgproc_pkg::msg_state_t msg_state;
	imgproc_pkg::word_t wr_data;
	imgproc_pkg::word_t mem [`MSG_FIFO_DEPTH];
	logic [`MSG_FIFO_AW-1:0] wr_ptr, rd_ptr;
	logic wr_en, do_wr, do_rd;

	// a message needs three free words
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			msg_state <= imgproc_pkg::MSG_IDLE;
		end else begin
			case (msg_state)
				imgproc_pkg::MSG_IDLE: begin
					if (msg_start && msg_fill < imgproc_pkg::fill_t'(`MSG_FIFO_DEPTH - 3)) begin
						msg_state <= imgproc_pkg::MSG_ID;
					end
				end
				imgproc_pkg::MSG_ID: msg_state <= imgproc_pkg::MSG_RED;
				imgproc_pkg::MSG_RED: msg_state <= imgproc_pkg::MSG_YELLOW;
				default: msg_state <= imgproc_pkg::MSG_IDLE;
			endcase
		end
	end

	always_comb begin
		case (msg_state)
			imgproc_pkg::MSG_ID: wr_data = `MSG_ID;
			imgproc_pkg::MSG_RED: wr_data = {5'b0, red_left, 5'b0, red_right};
			imgproc_pkg::MSG_YELLOW: wr_data = {5'b0, yel_left, 5'b0, yel_right};
			default: wr_data = '0;
		endcase
	end

	//////////////////////////////
	// fifo storage
	//////////////////////////////
	assign wr_en = msg_state != imgproc_pkg::MSG_IDLE;
	assign msg_empty = msg_fill == '0;
	assign do_wr = wr_en && msg_fill != imgproc_pkg::fill_t'(`MSG_FIFO_DEPTH);
	assign do_rd = msg_pop && !msg_empty;
	assign msg_q = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= wr_data;
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n || msg_flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			msg_fill <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_wr, do_rd})
				2'b10: msg_fill <= msg_fill + 1'b1;
				2'b01: msg_fill <= msg_fill - 1'b1;
				default: msg_fill <= msg_fill;
			endcase
		end
	end

endmodule

//--- rtl/mm_regs.sv
// memory-mapped register port
`include "imgproc_cfg.svh"

module mm_regs (
	input  logic               clk,
	input  logic               reset_n,
	input  logic               s_chipselect,
	input  logic               s_read,
	input  logic               s_write,
	input  logic [2:0]         s_address,
	input  imgproc_pkg::word_t s_writedata,
	output imgproc_pkg::word_t s_readdata,
	input  imgproc_pkg::word_t msg_q,
	input  imgproc_pkg::fill_t msg_fill,
	input  logic               msg_empty,
	output logic               msg_pop,
	output logic               msg_flush
);

	logic [7:0] reg_status;
	logic read_d;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			reg_status <= '0;
		end else if (s_chipselect && s_write && s_address == `ADDR_STATUS) begin
			reg_status <= s_writedata[7:0];
		end
	end

	assign msg_flush = s_chipselect && s_write && s_address == `ADDR_STATUS
		&& s_writedata[`FLUSH_BIT];

	// read data lands one cycle after the request
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			s_readdata <= '0;
			read_d <= 1'b0;
		end else begin
			read_d <= s_read;
			if (s_chipselect && s_read) begin
				case (s_address)
					`ADDR_STATUS: s_readdata <= {16'b0, 1'b0, msg_fill, reg_status};
					`ADDR_MSG: s_readdata <= msg_q;
					`ADDR_ID: s_readdata <= `ID_WORD;
					default: s_readdata <= '0;
				endcase
			end
		end
	end

	// advance the fifo once per read, after the head word is captured
	assign msg_pop = s_chipselect && s_read && !read_d && !msg_empty
		&& s_address == `ADDR_MSG;

endmodule

//--- rtl/eee_imgproc.sv
// colour tracker top level
`include "imgproc_cfg.svh"

module eee_imgproc #(
	parameter int img_w = `IMG_W,
	parameter int img_h = `IMG_H,
	parameter int horizon_y = `HORIZON_Y
) (
	input  logic               clk,
	input  logic               reset_n,
	input  logic               s_chipselect,
	input  logic               s_read,
	input  logic               s_write,
	input  logic [2:0]         s_address,
	input  imgproc_pkg::word_t s_writedata,
	output imgproc_pkg::word_t s_readdata,
	input  imgproc_pkg::rgb_t  sink_data,
	input  logic               sink_valid,
	input  logic               sink_sop,
	input  logic               sink_eop,
	output logic               sink_ready,
	output imgproc_pkg::rgb_t  source_data,
	output logic               source_valid,
	output logic               source_sop,
	output logic               source_eop,
	input  logic               source_ready,
	input  logic               mode
);

	imgproc_pkg::rgb_t in_pixel, out_pixel;
	imgproc_pkg::pix_class_t pix_class;
	imgproc_pkg::coord_t red_left, red_right, yel_left, yel_right;
	imgproc_pkg::word_t msg_q;
	imgproc_pkg::fill_t msg_fill;
	logic in_sop, in_eop, in_valid, out_ready, pix_accept;
	logic msg_start, msg_empty, msg_pop, msg_flush;

	// a pixel moves on when the output stage can take it
	assign pix_accept = in_valid && out_ready;

	//////////////////////////////
	// video path
	//////////////////////////////
	stream_reg in_reg (
		.clk(clk), .reset_n(reset_n),
		.data_in(sink_data), .sop_in(sink_sop), .eop_in(sink_eop),
		.valid_in(sink_valid), .ready_out(sink_ready),
		.data_out(in_pixel), .sop_out(in_sop), .eop_out(in_eop),
		.valid_out(in_valid), .ready_in(out_ready)
	);

	pixel_classify u_classify (
		.clk(clk), .reset_n(reset_n), .pixel(in_pixel), .sop(in_sop),
		.pix_accept(pix_accept), .pix_class(pix_class)
	);

	frame_tracker #(.img_w(img_w), .img_h(img_h), .horizon_y(horizon_y)) u_tracker (
		.clk(clk), .reset_n(reset_n), .mode(mode), .pixel(in_pixel),
		.sop(in_sop), .eop(in_eop), .pix_accept(pix_accept), .pix_class(pix_class),
		.out_pixel(out_pixel), .msg_start(msg_start),
		.red_left(red_left), .red_right(red_right),
		.yel_left(yel_left), .yel_right(yel_right)
	);

	stream_reg out_reg (
		.clk(clk), .reset_n(reset_n),
		.data_in(out_pixel), .sop_in(in_sop), .eop_in(in_eop),
		.valid_in(in_valid), .ready_out(out_ready),
		.data_out(source_data), .sop_out(source_sop), .eop_out(source_eop),
		.valid_out(source_valid), .ready_in(source_ready)
	);

	//////////////////////////////
	// messages and registers
	//////////////////////////////
	msg_fifo u_msg (
		.clk(clk), .reset_n(reset_n), .msg_start(msg_start),
		.red_left(red_left), .red_right(red_right),
		.yel_left(yel_left), .yel_right(yel_right),
		.msg_pop(msg_pop), .msg_flush(msg_flush),
		.msg_q(msg_q), .msg_fill(msg_fill), .msg_empty(msg_empty)
	);

	mm_regs u_regs (
		.clk(clk), .reset_n(reset_n),
		.s_chipselect(s_chipselect), .s_read(s_read), .s_write(s_write),
		.s_address(s_address), .s_writedata(s_writedata), .s_readdata(s_readdata),
		.msg_q(msg_q), .msg_fill(msg_fill), .msg_empty(msg_empty),
		.msg_pop(msg_pop), .msg_flush(msg_flush)
	);

endmodule

//--- testbench/eee_imgproc_chk.sv
// stream protocol checker
module eee_imgproc_chk (
	input logic              clk,
	input logic              reset_n,
	input logic              sink_valid,
	input logic              sink_ready,
	input logic              sink_sop,
	input logic              sink_eop,
	input imgproc_pkg::rgb_t source_data,
	input logic              source_valid,
	input logic              source_ready,
	input logic              source_sop,
	input logic              source_eop
);
	timeunit 1ns;
	timeprecision 100ps;

	int unsigned fail_count = 0;
	logic [1:0] flag_mem [8];
	logic [2:0] wr_idx, rd_idx;

	// sop and eop of the words in flight, in sink order
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			wr_idx <= '0;
			rd_idx <= '0;
		end else begin
			if (sink_valid && sink_ready) begin
				flag_mem[wr_idx] <= {sink_sop, sink_eop};
				wr_idx <= wr_idx + 1'b1;
			end
			if (source_valid && source_ready) begin
				rd_idx <= rd_idx + 1'b1;
			end
		end
	end

	reset_quiet: assert property (@(posedge clk) !reset_n |=> !source_valid)
		else begin
			fail_count++;
			$error("source_valid high after a reset cycle");
		end

	hold_stable: assert property (@(posedge clk) disable iff (!reset_n)
		source_valid && !source_ready |=> source_valid && $stable(source_data)
			&& $stable(source_sop) && $stable(source_eop))
		else begin
			fail_count++;
			$error("source word changed while stalled");
		end

	keep_order: assert property (@(posedge clk) disable iff (!reset_n)
		source_valid && source_ready |-> {source_sop, source_eop} == flag_mem[rd_idx])
		else begin
			fail_count++;
			$error("source packet flags out of sink order");
		end

endmodule

bind eee_imgproc eee_imgproc_chk u_chk (
	.clk(clk),
	.reset_n(reset_n),
	.sink_valid(sink_valid),
	.sink_ready(sink_ready),
	.sink_sop(sink_sop),
	.sink_eop(sink_eop),
	.source_data(source_data),
	.source_valid(source_valid),
	.source_ready(source_ready),
	.source_sop(source_sop),
	.source_eop(source_eop)
);

//--- testbench/tb_eee_imgproc.sv
// colour tracker testbench
`include "imgproc_cfg.svh"

module tb_eee_imgproc;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int img_w = 32;
	localparam int img_h = 16;
	localparam int horizon_y = 8;
	localparam int frame_px = img_w * img_h;
	localparam int other_len = 20;
	localparam int total_words = 7 * (frame_px + 1) + 2 * (other_len + 1);
	localparam int timeout_ns = total_words * 8 * 4 + 20000;
	localparam imgproc_pkg::coord_t x_last = imgproc_pkg::coord_t'(img_w - 1);
	localparam imgproc_pkg::rgb_t pure_red = 24'hff0000;
	localparam imgproc_pkg::rgb_t pure_yel = 24'hffff00;

	logic clk, reset_n, mode;
	logic s_chipselect, s_read, s_write;
	logic [2:0] s_address;
	imgproc_pkg::word_t s_writedata, s_readdata;
	imgproc_pkg::rgb_t sink_data, source_data;
	logic sink_valid, sink_sop, sink_eop, sink_ready;
	logic source_valid, source_sop, source_eop, source_ready;

	integer seed;
	logic gap;
	string test_name;
	// stream words are {sop, eop, pixel}
	logic [25:0] stim_q [$];
	logic [25:0] exp_q [$];
	imgproc_pkg::word_t msg_exp [$];
	imgproc_pkg::coord_t red_l_m, red_r_m, yel_l_m, yel_r_m;
	int frame_cnt_m;
	logic [7:0] status_m;
	imgproc_pkg::word_t rd_data;

	eee_imgproc #(.img_w(img_w), .img_h(img_h), .horizon_y(horizon_y)) i_dut (.*);

	always #4 clk = ~clk;

	task automatic report_failure();
		$display("Regression failed");
		$fatal(1);
	endtask

	task automatic check_value(input string what, input imgproc_pkg::word_t expected,
			input imgproc_pkg::word_t actual);
		assert (actual === expected) else begin
			$display("CHECK FAILED %s %s expected %h actual %h", test_name, what, expected, actual);
			report_failure();
		end
	endtask

	function automatic imgproc_pkg::rgb_t grey_of(input imgproc_pkg::rgb_t p);
		imgproc_pkg::chan_t v;
		v = p[15:8] / 2 + p[23:16] / 4 + p[7:0] / 4;
		return {v, v, v};
	endfunction

	function automatic imgproc_pkg::word_t status_word();
		return {16'h0, 1'b0, 7'(msg_exp.size()), status_m};
	endfunction

	//////////////////////////////
	// register port
	//////////////////////////////
	task automatic read_reg(input logic [2:0] addr, output imgproc_pkg::word_t data);
		@(negedge clk);
		s_chipselect = 1'b1;
		s_read = 1'b1;
		s_address = addr;
		@(negedge clk);
		data = s_readdata;
		s_chipselect = 1'b0;
		s_read = 1'b0;
	endtask

	task automatic write_reg(input logic [2:0] addr, input imgproc_pkg::word_t data);
		@(negedge clk);
		s_chipselect = 1'b1;
		s_write = 1'b1;
		s_address = addr;
		s_writedata = data;
		@(negedge clk);
		s_chipselect = 1'b0;
		s_write = 1'b0;
	endtask

	// status first, then empty the fifo word by word
	task automatic check_messages(input logic pop_all);
		imgproc_pkg::word_t data;
		int n;
		repeat (5) @(negedge clk);
		read_reg(`ADDR_STATUS, data);
		check_value("status fill", status_word(), data);
		if (pop_all) begin
			n = msg_exp.size();
			while (msg_exp.size() != 0) begin
				read_reg(`ADDR_MSG, data);
				check_value("message word", msg_exp.pop_front(), data);
			end
			if (n != 0) begin
				read_reg(`ADDR_STATUS, data);
				check_value("status after reads", status_word(), data);
			end
		end
	endtask

	//////////////////////////////
	// video stream
	//////////////////////////////
	task automatic drain();
		while (stim_q.size() != 0 || exp_q.size() != 0) begin
			@(negedge clk);
		end
	endtask

	task automatic send_other(input int len);
		imgproc_pkg::rgb_t p;
		int i;
		// queue new words away from the falling edge where the driver reads them
		@(posedge clk);
		stim_q.push_back({2'b10, 24'h00000a});
		exp_q.push_back({2'b10, 24'h00000a});
		for (i = 0; i < len; i++) begin
			p = {8'(i * 37), 8'(i * 11), 8'(i * 53 + 10)};
			if (i % 4 == 0) begin
				p = pure_red;
			end
			stim_q.push_back({1'b0, i == len - 1, p});
			exp_q.push_back({1'b0, i == len - 1, p});
		end
		drain();
	endtask

	task automatic send_video(input int red_row, input int red_x0, input int red_len,
			input int yel_row, input int yel_x0, input int yel_len);
		imgproc_pkg::rgb_t pix [frame_px];
		imgproc_pkg::rgb_t want;
		imgproc_pkg::coord_t x, y, rmin, rmax, ymin, ymax;
		int red_run, yel_run, i;
		logic red_ok, yel_ok;
		for (i = 0; i < frame_px; i++) begin
			pix[i] = {3{imgproc_pkg::chan_t'(i)}};
		end
		// a red run on the horizon row and one too short for the filter
		for (i = 2; i <= 12; i++) begin
			pix[horizon_y * img_w + i] = pure_red;
		end
		for (i = 20; i <= 24; i++) begin
			pix[3 * img_w + i] = pure_red;
		end
		for (i = 0; i < red_len; i++) begin
			pix[red_row * img_w + red_x0 + i] = pure_red;
		end
		for (i = 0; i < yel_len; i++) begin
			pix[yel_row * img_w + yel_x0 + i] = pure_yel;
		end
		red_run = 0;
		yel_run = 0;
		rmin = x_last;
		rmax = '0;
		ymin = x_last;
		ymax = '0;
		@(posedge clk);
		stim_q.push_back({2'b10, 24'h000000});
		exp_q.push_back({2'b10, 24'h000000});
		for (i = 0; i < frame_px; i++) begin
			x = imgproc_pkg::coord_t'(i % img_w);
			y = imgproc_pkg::coord_t'(i / img_w);
			red_run = (pix[i] == pure_red) ? red_run + 1 : 0;
			yel_run = (pix[i] == pure_yel) ? yel_run + 1 : 0;
			red_ok = red_run > `RUN_LEN;
			yel_ok = yel_run > `RUN_LEN;
			if (red_ok) begin
				want = `RED_FILL;
			end else if (yel_ok) begin
				want = `YEL_FILL;
			end else begin
				want = grey_of(pix[i]);
			end
			// box lines from the previous video frame, yellow drawn last
			if ((x == red_l_m && red_l_m != x_last) || (x == red_r_m && red_r_m != 0)) begin
				want = `RED_BOX;
			end
			if ((x == yel_l_m && yel_l_m != x_last) || (x == yel_r_m && yel_r_m != 0)) begin
				want = `YEL_BOX;
			end
			if (!mode) begin
				want = pix[i];
			end
			if (y > horizon_y && red_ok) begin
				rmin = (x < rmin) ? x : rmin;
				rmax = (x > rmax) ? x : rmax;
			end
			if (y > horizon_y && yel_ok) begin
				ymin = (x < ymin) ? x : ymin;
				ymax = (x > ymax) ? x : ymax;
			end
			stim_q.push_back({1'b0, i == frame_px - 1, pix[i]});
			exp_q.push_back({1'b0, i == frame_px - 1, want});
		end
		drain();
		red_l_m = rmin;
		red_r_m = rmax;
		yel_l_m = ymin;
		yel_r_m = ymax;
		if (frame_cnt_m == 0) begin
			if (msg_exp.size() < `MSG_FIFO_DEPTH - 3) begin
				msg_exp.push_back(`MSG_ID);
				msg_exp.push_back({5'b0, red_l_m, 5'b0, red_r_m});
				msg_exp.push_back({5'b0, yel_l_m, 5'b0, yel_r_m});
			end
			frame_cnt_m = `MSG_INTERVAL - 1;
		end else begin
			frame_cnt_m--;
		end
	endtask

	// drive on the falling edge, look at the handshake just before the rising edge
	always @(negedge clk) begin
		if (reset_n) begin
			source_ready = ($random(seed) & 3) != 0;
			gap = ($random(seed) & 3) == 0;
			if (stim_q.size() != 0 && !gap) begin
				{sink_sop, sink_eop, sink_data} = stim_q[0];
				sink_valid = 1'b1;
			end else begin
				sink_valid = 1'b0;
			end
			#3;
			if (sink_valid && sink_ready) begin
				stim_q.delete(0);
			end
			if (source_valid && source_ready) begin
				if (exp_q.size() == 0) begin
					$display("source sent a word that no stimulus accounts for");
					report_failure();
				end else begin
					check_value("source word", 32'(exp_q.pop_front()),
						{6'b0, source_sop, source_eop, source_data});
				end
			end
		end
	end

	always @(negedge clk) begin
		if (i_dut.u_chk.fail_count != 0) begin
			$display("a stream protocol assertion in the bound checker failed");
			report_failure();
		end
	end

	initial begin
		#(timeout_ns);
		$display("watchdog timeout, the run did not finish in %0d ns", timeout_ns);
		report_failure();
	end

	initial begin
		clk = 1'b0;
		reset_n = 1'b0;
		mode = 1'b0;
		seed = 16124;
		s_chipselect = 1'b0;
		s_read = 1'b0;
		s_write = 1'b0;
		s_address = '0;
		s_writedata = '0;
		sink_data = '0;
		sink_valid = 1'b0;
		sink_sop = 1'b0;
		sink_eop = 1'b0;
		source_ready = 1'b0;
		red_l_m = x_last;
		red_r_m = '0;
		yel_l_m = x_last;
		yel_r_m = '0;
		frame_cnt_m = 0;
		status_m = '0;
		repeat (16) @(negedge clk);
		reset_n = 1'b1;

		test_name = "passthrough";
		send_video(10, 4, 12, 12, 14, 10);
		check_messages(1'b1);
		send_other(other_len);

		test_name = "overlay";
		mode = 1'b1;
		send_video(9, 0, 20, 14, 8, 16);
		check_messages(1'b1);
		send_other(other_len);
		send_video(11, 2, 30, 0, 0, 0);
		check_messages(1'b1);
		send_video(0, 0, 0, 15, 5, 20);
		check_messages(1'b1);
		send_video(0, 0, 0, 0, 0, 0);
		check_messages(1'b1);
		mode = 1'b0;
		send_video(13, 1, 9, 10, 16, 8);
		check_messages(1'b1);
		mode = 1'b1;
		send_video(9, 3, 7, 15, 24, 8);

		test_name = "registers";
		check_messages(1'b0);
		write_reg(`ADDR_STATUS, 32'h0000_0010);
		status_m = 8'h10;
		msg_exp.delete();
		check_messages(1'b0);
		read_reg(`ADDR_ID, rd_data);
		check_value("id word", `ID_WORD, rd_data);
		read_reg(3'd5, rd_data);
		check_value("unused address", 32'h0, rd_data);

		if (i_dut.u_chk.fail_count == 0) begin
			$display("Regression passed");
			$finish;
		end else begin
			report_failure();
		end
	end

endmodule

//--- vlog.f
+incdir+rtl
rtl/imgproc_pkg.sv
rtl/stream_reg.sv
rtl/pixel_classify.sv
rtl/frame_tracker.sv
rtl/msg_fifo.sv
rtl/mm_regs.sv
rtl/eee_imgproc.sv
testbench/eee_imgproc_chk.sv
testbench/tb_eee_imgproc.sv
